//--- common/cache_pkg.sv
package cache_pkg;

    // processor side of the cache
    localparam int FE_ADDR_W = 32;              // byte address
    localparam int FE_DATA_W = 32;              // one word
    localparam int FE_NBYTES = FE_DATA_W / 8;
    localparam int FE_BYTE_W = $clog2(FE_NBYTES); // byte offset bits inside a word

    // word address width, byte offset dropped
    localparam int FE_WADDR_W = FE_ADDR_W - FE_BYTE_W;

    // front port holding register
    typedef enum logic
    {
        EMPTY = 1'b0,
        HELD  = 1'b1
    } port_state_e;

endpackage

//--- common/axi_pkg.sv
package axi_pkg;

    localparam int AXI_ID_W = 4;

    typedef enum logic [1:0]
    {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    localparam logic [3:0] AWCACHE_NORMAL = 4'b0011; // modifiable, bufferable
    localparam logic [7:0] AWLEN_SINGLE   = 8'd0;    // one beat per transfer

    typedef enum logic [1:0]
    {
        IDLE    = 2'd0,
        ADDRESS = 2'd1,
        WRITE   = 2'd2,
        VERIFY  = 2'd3
    } wch_state_e;

endpackage

//--- hdl/front_write_port.sv
`timescale 1ns/1ps

module front_write_port
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_valid,
    input  logic [cache_pkg::FE_ADDR_W-1:0]    wr_addr,
    input  logic [cache_pkg::FE_DATA_W-1:0]    wr_data,
    input  logic [cache_pkg::FE_NBYTES-1:0]    wr_strb,
    output logic                               wr_ready,
    input  logic                               full,
    output logic                               push,
    output logic [cache_pkg::FE_WADDR_W-1:0]   push_addr,
    output logic [cache_pkg::FE_DATA_W-1:0]    push_data,
    output logic [cache_pkg::FE_NBYTES-1:0]    push_strb,
    output logic                               empty_port
);

    cache_pkg::port_state_e             state;
    logic [cache_pkg::FE_WADDR_W-1:0]   held_addr;
    logic [cache_pkg::FE_DATA_W-1:0]    held_data;
    logic [cache_pkg::FE_NBYTES-1:0]    held_strb;
    logic                               same_word;
    logic                               accept;
    logic                               merge;

    assign same_word  = held_addr == wr_addr[cache_pkg::FE_ADDR_W-1:cache_pkg::FE_BYTE_W];
    assign empty_port = state == cache_pkg::EMPTY;
    assign push       = (state == cache_pkg::HELD) & ~full; // leaves as soon as there is room
    assign wr_ready   = empty_port | same_word | ~full;
    assign accept     = wr_valid & wr_ready;

    // a held word that is not leaving this cycle can only take a same-word write
    assign merge = (state == cache_pkg::HELD) & ~push;

    assign push_addr = held_addr;
    assign push_data = held_data;
    assign push_strb = held_strb;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= cache_pkg::EMPTY;
        else if (accept)
            state <= cache_pkg::HELD; // new or merged word waits
        else if (push)
            state <= cache_pkg::EMPTY;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            for (int i = 0; i < cache_pkg::FE_NBYTES; i++)
            begin
                if (!merge || wr_strb[i])
                    held_data[8*i +: 8] <= wr_data[8*i +: 8]; // newer bytes win
            end
            held_strb <= merge ? (held_strb | wr_strb) : wr_strb;
            held_addr <= wr_addr[cache_pkg::FE_ADDR_W-1:cache_pkg::FE_BYTE_W];
        end
    end

endmodule

//--- write_buffer/write_buffer.sv
`timescale 1ns/1ps

module write_buffer
#(
    parameter int BUF_DEPTH = 4 // power of two, at least 2
)
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               push,
    input  logic [cache_pkg::FE_WADDR_W-1:0]   push_addr,
    input  logic [cache_pkg::FE_DATA_W-1:0]    push_data,
    input  logic [cache_pkg::FE_NBYTES-1:0]    push_strb,
    output logic                               full,
    input  logic                               pop,
    output logic                               nonempty,
    output logic [cache_pkg::FE_WADDR_W-1:0]   head_addr,
    output logic [cache_pkg::FE_DATA_W-1:0]    head_data,
    output logic [cache_pkg::FE_NBYTES-1:0]    head_strb
);

    localparam int IDX_W = $clog2(BUF_DEPTH);

    logic [cache_pkg::FE_WADDR_W-1:0]   addr_mem [BUF_DEPTH];
    logic [cache_pkg::FE_DATA_W-1:0]    data_mem [BUF_DEPTH];
    logic [cache_pkg::FE_NBYTES-1:0]    strb_mem [BUF_DEPTH];

    // extra msb tells a wrapped write pointer from an equal one
    logic [IDX_W:0] wr_ptr;
    logic [IDX_W:0] rd_ptr;

    assign nonempty = wr_ptr != rd_ptr;
    assign full     = (wr_ptr[IDX_W] != rd_ptr[IDX_W])
                    && (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

    assign head_addr = addr_mem[rd_ptr[IDX_W-1:0]];
    assign head_data = data_mem[rd_ptr[IDX_W-1:0]];
    assign head_strb = strb_mem[rd_ptr[IDX_W-1:0]];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // caller already checked full
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            addr_mem[wr_ptr[IDX_W-1:0]] <= push_addr;
            data_mem[wr_ptr[IDX_W-1:0]] <= push_data;
            strb_mem[wr_ptr[IDX_W-1:0]] <= push_strb;
        end
    end

endmodule

//--- axi_write/write_channel_axi.sv
`timescale 1ns/1ps

module write_channel_axi
#(
    parameter int BE_DATA_W = 32, // 32 or 64
    parameter logic [axi_pkg::AXI_ID_W-1:0] AXI_ID = '0
)
(
    input  logic                               clk,
    input  logic                               reset,
    // head of the write buffer
    input  logic                               valid,
    input  logic [cache_pkg::FE_WADDR_W-1:0]   addr,
    input  logic [cache_pkg::FE_DATA_W-1:0]    wdata,
    input  logic [cache_pkg::FE_NBYTES-1:0]    wstrb,
    output logic                               ready,
    // AXI write address
    output logic                               axi_awvalid,
    output logic [cache_pkg::FE_ADDR_W-1:0]    axi_awaddr,
    output logic [7:0]                         axi_awlen,
    output logic [2:0]                         axi_awsize,
    output logic [1:0]                         axi_awburst,
    output logic [3:0]                         axi_awcache,
    output logic [axi_pkg::AXI_ID_W-1:0]       axi_awid,
    input  logic                               axi_awready,
    // AXI write data
    output logic                               axi_wvalid,
    output logic [BE_DATA_W-1:0]               axi_wdata,
    output logic [BE_DATA_W/8-1:0]             axi_wstrb,
    output logic                               axi_wlast,
    input  logic                               axi_wready,
    // AXI write response
    input  logic                               axi_bvalid,
    input  logic [1:0]                         axi_bresp,
    output logic                               axi_bready,
    output logic                               idle
);

    localparam int BE_NBYTES = BE_DATA_W / 8;
    localparam int BE_BYTE_W = $clog2(BE_NBYTES);
    localparam int LANES     = BE_DATA_W / cache_pkg::FE_DATA_W;

    axi_pkg::wch_state_e state;
    logic                resp_ok;

    // fixed transfer attributes
    assign axi_awid    = AXI_ID;
    assign axi_awlen   = axi_pkg::AWLEN_SINGLE;
    assign axi_awsize  = 3'(BE_BYTE_W);    // full backend word per beat
    assign axi_awburst = axi_pkg::FIXED;
    assign axi_awcache = axi_pkg::AWCACHE_NORMAL;
    assign axi_wlast   = axi_wvalid;       // single beat

    // byte address aligned down to the backend word
    assign axi_awaddr = {addr[cache_pkg::FE_WADDR_W-1:BE_BYTE_W-cache_pkg::FE_BYTE_W],
                         {BE_BYTE_W{1'b0}}};

    // same word on every lane, strobes pick the one that counts
    assign axi_wdata = {LANES{wdata}};

    generate
        if (LANES == 1)
        begin : g_narrow
            assign axi_wstrb = wstrb;
        end
        else
        begin : g_wide
            logic [BE_BYTE_W-cache_pkg::FE_BYTE_W-1:0] lane;

            assign lane      = addr[BE_BYTE_W-cache_pkg::FE_BYTE_W-1:0]; // word within the beat
            assign axi_wstrb = {{(BE_NBYTES-cache_pkg::FE_NBYTES){1'b0}}, wstrb}
                               << (lane * cache_pkg::FE_NBYTES);
        end
    endgenerate

    assign resp_ok = axi_bresp == axi_pkg::OKAY;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= axi_pkg::IDLE;
        else
        begin
            case (state)
                axi_pkg::IDLE:
                    if (valid)
                        state <= axi_pkg::ADDRESS;
                axi_pkg::ADDRESS:
                    if (axi_awready)
                        state <= axi_pkg::WRITE;
                axi_pkg::WRITE:
                    if (axi_wready)
                        state <= axi_pkg::VERIFY;
                axi_pkg::VERIFY:
                    if (axi_bvalid)
                    begin
                        // head is popped on OKAY, so look at valid again from IDLE
                        if (resp_ok)
                            state <= axi_pkg::IDLE;
                        else
                            state <= axi_pkg::ADDRESS; // replay the same entry
                    end
                default:
                    state <= axi_pkg::IDLE;
            endcase
        end
    end

    // handshake outputs follow the state only
    assign idle        = state == axi_pkg::IDLE;
    assign axi_awvalid = state == axi_pkg::ADDRESS;
    assign axi_wvalid  = state == axi_pkg::WRITE;
    assign axi_bready  = state == axi_pkg::VERIFY;
    assign ready       = axi_bready & axi_bvalid & resp_ok; // pop pulse

endmodule

//--- hdl/cache_write_path.sv
`timescale 1ns/1ps

module cache_write_path
#(
    parameter int BE_DATA_W = 32,
    parameter int BUF_DEPTH = 4,
    parameter logic [axi_pkg::AXI_ID_W-1:0] AXI_ID = '0
)
(
    input  logic                               clk,
    input  logic                               reset,
    // processor side
    input  logic                               wr_valid,
    input  logic [cache_pkg::FE_ADDR_W-1:0]    wr_addr,
    input  logic [cache_pkg::FE_DATA_W-1:0]    wr_data,
    input  logic [cache_pkg::FE_NBYTES-1:0]    wr_strb,
    output logic                               wr_ready,
    output logic                               drained,
    // AXI write address
    output logic                               axi_awvalid,
    output logic [cache_pkg::FE_ADDR_W-1:0]    axi_awaddr,
    output logic [7:0]                         axi_awlen,
    output logic [2:0]                         axi_awsize,
    output logic [1:0]                         axi_awburst,
    output logic [3:0]                         axi_awcache,
    output logic [axi_pkg::AXI_ID_W-1:0]       axi_awid,
    input  logic                               axi_awready,
    // AXI write data
    output logic                               axi_wvalid,
    output logic [BE_DATA_W-1:0]               axi_wdata,
    output logic [BE_DATA_W/8-1:0]             axi_wstrb,
    output logic                               axi_wlast,
    input  logic                               axi_wready,
    // AXI write response
    input  logic                               axi_bvalid,
    input  logic [1:0]                         axi_bresp,
    output logic                               axi_bready
);

    logic                               full;
    logic                               push;
    logic [cache_pkg::FE_WADDR_W-1:0]   push_addr;
    logic [cache_pkg::FE_DATA_W-1:0]    push_data;
    logic [cache_pkg::FE_NBYTES-1:0]    push_strb;
    logic                               empty_port;
    logic                               nonempty;
    logic                               pop;
    logic [cache_pkg::FE_WADDR_W-1:0]   head_addr;
    logic [cache_pkg::FE_DATA_W-1:0]    head_data;
    logic [cache_pkg::FE_NBYTES-1:0]    head_strb;
    logic                               channel_idle;

    assign drained = empty_port & ~nonempty & channel_idle; // nothing left anywhere

    front_write_port front_i
    (
        .clk        (clk),
        .reset      (reset),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .wr_ready   (wr_ready),
        .full       (full),
        .push       (push),
        .push_addr  (push_addr),
        .push_data  (push_data),
        .push_strb  (push_strb),
        .empty_port (empty_port)
    );

    write_buffer #(.BUF_DEPTH(BUF_DEPTH)) buffer_i
    (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_addr (push_addr),
        .push_data (push_data),
        .push_strb (push_strb),
        .full      (full),
        .pop       (pop),
        .nonempty  (nonempty),
        .head_addr (head_addr),
        .head_data (head_data),
        .head_strb (head_strb)
    );

    write_channel_axi #(.BE_DATA_W(BE_DATA_W), .AXI_ID(AXI_ID)) channel_i
    (
        .clk         (clk),
        .reset       (reset),
        .valid       (nonempty),
        .addr        (head_addr),
        .wdata       (head_data),
        .wstrb       (head_strb),
        .ready       (pop),
        .axi_awvalid (axi_awvalid),
        .axi_awaddr  (axi_awaddr),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_awcache (axi_awcache),
        .axi_awid    (axi_awid),
        .axi_awready (axi_awready),
        .axi_wvalid  (axi_wvalid),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .axi_bresp   (axi_bresp),
        .axi_bready  (axi_bready),
        .idle        (channel_idle)
    );

endmodule

//--- dv/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model
#(
    parameter int BE_DATA_W = 64,
    parameter int MEM_BYTES = 256
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   axi_awvalid,
    input  logic [31:0]            axi_awaddr,
    output logic                   axi_awready,
    input  logic                   axi_wvalid,
    input  logic [BE_DATA_W-1:0]   axi_wdata,
    input  logic [BE_DATA_W/8-1:0] axi_wstrb,
    output logic                   axi_wready,
    output logic                   axi_bvalid,
    output logic [1:0]             axi_bresp,
    input  logic                   axi_bready,
    input  logic                   inject_valid,   // adds inject_count error responses
    input  logic [7:0]             inject_count,
    output logic                   lane_violation
);

    localparam int BE_NBYTES = BE_DATA_W / 8;

    typedef enum logic [1:0]
    {
        S_AW = 2'd0,
        S_W  = 2'd1,
        S_B  = 2'd2
    } slave_state_e;

    slave_state_e           state;
    logic [1:0]             delay;         // cycles left before the next ready or bvalid
    logic [7:0]             errors_left;
    logic                   take_error;
    logic [31:0]            addr_q;
    logic [BE_DATA_W-1:0]   data_q;
    logic [BE_NBYTES-1:0]   strb_q;
    logic [7:0]             mem [MEM_BYTES];

    assign axi_awready    = state == S_AW && delay == 0;
    assign axi_wready     = state == S_W && delay == 0;
    assign axi_bvalid     = state == S_B && delay == 0;
    assign take_error     = axi_wvalid && axi_wready && errors_left != 0;
    assign lane_violation = axi_wvalid && axi_wready && (|axi_wstrb[3:0])
                          && (|(axi_wstrb >> 4));

    function automatic logic [31:0] peek_word(input logic [31:0] byte_addr);
        logic [31:0] word;
        for (int i = 0; i < 4; i++)
            word[8*i +: 8] = mem[(byte_addr + i) % MEM_BYTES];
        return word;
    endfunction

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= S_AW;
            delay       <= 2'd0;
            errors_left <= 8'd0;
            axi_bresp   <= axi_pkg::OKAY;
            for (int i = 0; i < MEM_BYTES; i++)
                mem[i] <= 8'(i) ^ 8'h5a; // background so an unwritten byte shows
        end
        else
        begin
            errors_left <= errors_left + (inject_valid ? inject_count : 8'd0)
                         - {7'd0, take_error};
            case (state)
                S_AW:
                    if (axi_awvalid && axi_awready)
                    begin
                        addr_q <= axi_awaddr;
                        state  <= S_W;
                        delay  <= 2'($urandom_range(3, 0));
                    end
                    else if (axi_awvalid)
                        delay <= delay - 2'd1;
                S_W:
                    if (axi_wvalid && axi_wready)
                    begin
                        data_q    <= axi_wdata;
                        strb_q    <= axi_wstrb;
                        axi_bresp <= take_error ? axi_pkg::SLVERR : axi_pkg::OKAY;
                        state     <= S_B;
                        delay     <= 2'($urandom_range(3, 0));
                    end
                    else if (axi_wvalid)
                        delay <= delay - 2'd1;
                default:
                    if (axi_bvalid && axi_bready)
                    begin
                        if (axi_bresp == axi_pkg::OKAY)
                            for (int i = 0; i < BE_NBYTES; i++)
                                if (strb_q[i])
                                    mem[(addr_q + i) % MEM_BYTES] <= data_q[8*i +: 8];
                        state <= S_AW;
                        delay <= 2'($urandom_range(3, 0));
                    end
                    else if (!axi_bvalid)
                        delay <= delay - 2'd1;
            endcase
        end
    end

endmodule

//--- dv/cache_write_path_asserts.sv
`timescale 1ns/1ps

module cache_write_path_asserts
#(
    parameter int BE_DATA_W = 64
)
(
    input logic                   clk,
    input logic                   reset,
    input logic                   axi_awvalid,
    input logic                   axi_awready,
    input logic [31:0]            axi_awaddr,
    input logic                   axi_wvalid,
    input logic                   axi_wready,
    input logic [BE_DATA_W-1:0]   axi_wdata,
    input logic [BE_DATA_W/8-1:0] axi_wstrb
);

    int failures = 0;

    aw_held: assert property (@(posedge clk) disable iff (reset)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
    else
    begin
        $error("awvalid dropped or awaddr moved before awready");
        failures++;
    end

    w_stable: assert property (@(posedge clk) disable iff (reset)
        axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata) && $stable(axi_wstrb))
    else
    begin
        $error("write data or strobes changed while waiting for wready");
        failures++;
    end

endmodule

bind cache_write_path cache_write_path_asserts #(.BE_DATA_W(BE_DATA_W)) asserts_i
(
    .clk         (clk),
    .reset       (reset),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_awaddr  (axi_awaddr),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_wdata   (axi_wdata),
    .axi_wstrb   (axi_wstrb)
);

//--- dv/cache_write_path_tb.sv
`timescale 1ns/1ps

module cache_write_path_tb;

    localparam int BE_DATA_W       = 64;
    localparam int BUF_DEPTH       = 4;
    localparam int MEM_BYTES       = 256;
    localparam int CYCLES_PER_LINE = 200;
    localparam logic [axi_pkg::AXI_ID_W-1:0] AXI_ID = 4'h3;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         wr_valid;
    logic [31:0]                  wr_addr;
    logic [31:0]                  wr_data;
    logic [3:0]                   wr_strb;
    logic                         wr_ready;
    logic                         drained;
    logic                         axi_awvalid;
    logic [31:0]                  axi_awaddr;
    logic [7:0]                   axi_awlen;
    logic [2:0]                   axi_awsize;
    logic [1:0]                   axi_awburst;
    logic [3:0]                   axi_awcache;
    logic [axi_pkg::AXI_ID_W-1:0] axi_awid;
    logic                         axi_awready;
    logic                         axi_wvalid;
    logic [BE_DATA_W-1:0]         axi_wdata;
    logic [BE_DATA_W/8-1:0]       axi_wstrb;
    logic                         axi_wlast;
    logic                         axi_wready;
    logic                         axi_bvalid;
    logic [1:0]                   axi_bresp;
    logic                         axi_bready;
    logic                         inject_valid;
    logic [7:0]                   inject_count;
    logic                         lane_violation;

    string       kind_q[$];
    string       name_q[$];
    logic [31:0] arg_a_q[$];
    logic [31:0] arg_b_q[$];
    logic [31:0] arg_c_q[$];
    logic [7:0]  ref_mem [MEM_BYTES]; // expected bytes with writes applied in issue order

    int checks       = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycles       = 0;
    int cycle_limit  = 0;

    always #10 clk = ~clk;

    cache_write_path #(.BE_DATA_W(BE_DATA_W), .BUF_DEPTH(BUF_DEPTH), .AXI_ID(AXI_ID)) dut_i (.*);

    axi_slave_model #(.BE_DATA_W(BE_DATA_W), .MEM_BYTES(MEM_BYTES)) slave_i (.*);

    function automatic int total_errors();
        return value_errors + other_errors + dut_i.asserts_i.failures;
    endfunction

    function automatic logic [31:0] reference_word(input logic [31:0] addr);
        logic [31:0] word;
        for (int i = 0; i < 4; i++)
            word[8*i +: 8] = ref_mem[((addr & ~32'd3) + i) % MEM_BYTES];
        return word;
    endfunction

    task automatic update_reference(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [3:0] strb);
        for (int i = 0; i < 4; i++)
            if (strb[i])
                ref_mem[((addr & ~32'd3) + i) % MEM_BYTES] = data[8*i +: 8]; // newer byte wins
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       kind;
        string       name;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("dv/write_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file dv/write_trace.txt");
            other_errors++;
        end
        else
        begin
            while ($fscanf(fd, "%s", kind) == 1)
            begin
                name = "";
                a = '0;
                b = '0;
                c = '0;
                if (kind == "W")
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                else if (kind == "E")
                    n = $fscanf(fd, "%d", a);
                else if (kind == "C")
                    n = $fscanf(fd, "%s %h %h", name, a, b);
                else
                    n = $fgets(rest, fd); // comment line is dropped
                if (kind == "W" || kind == "E" || kind == "C")
                begin
                    kind_q.push_back(kind);
                    name_q.push_back(name);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                    arg_c_q.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_drained();
        do
            @(negedge clk);
        while (!drained);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] addr,
                              input logic [31:0] expected);
        logic [31:0] actual;
        logic [31:0] model;
        actual = slave_i.peek_word(addr);
        model  = reference_word(addr);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            value_errors++;
        end
        assert (actual === model)
        else
        begin
            $display("CHECK FAILED %s vs reference memory: expected 0x%08h, actual 0x%08h",
                     name, model, actual);
            value_errors++;
        end
    endtask

    // every word of the slave memory against the reference, so no write goes missing
    task automatic compare_memory();
        logic [31:0] actual;
        logic [31:0] model;
        for (int a = 0; a < MEM_BYTES; a += 4)
        begin
            actual = slave_i.peek_word(a);
            model  = reference_word(a);
            checks++;
            assert (actual === model)
            else
            begin
                $display("CHECK FAILED final_memory_%02h: expected 0x%08h, actual 0x%08h",
                         a, model, actual);
                value_errors++;
            end
        end
    endtask

    task automatic run_record(input int n);
        @(posedge clk);
        wr_valid     <= 1'b0;
        inject_valid <= 1'b0;
        if (kind_q[n] == "W")
        begin
            wr_valid <= 1'b1;
            wr_addr  <= arg_a_q[n];
            wr_data  <= arg_b_q[n];
            wr_strb  <= arg_c_q[n][3:0];
            update_reference(arg_a_q[n], arg_b_q[n], arg_c_q[n][3:0]);
            do
                @(negedge clk);
            while (!wr_ready); // taken on the next rising edge
        end
        else if (kind_q[n] == "E")
        begin
            inject_valid <= 1'b1;
            inject_count <= arg_a_q[n][7:0];
        end
        else
        begin
            wait_drained();
            check_word(name_q[n], arg_a_q[n], arg_b_q[n]);
        end
    endtask

    task automatic print_counts();
        $display("checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
                 checks, value_errors, other_errors, dut_i.asserts_i.failures);
    endtask

    // a beat from a 32-bit write must stay inside one lane
    always @(negedge clk)
    begin
        if (!reset)
            assert (!lane_violation)
            else
            begin
                $display("write strobes 0x%02h touch both 32-bit lanes of one beat", axi_wstrb);
                other_errors++;
            end
    end

    // attributes of a single-beat write-through transfer
    always @(negedge clk)
    begin
        if (!reset && axi_awvalid)
        begin
            check_value("awlen", 32'd0, 32'(axi_awlen));
            check_value("awsize", 32'($clog2(BE_DATA_W / 8)), 32'(axi_awsize));
            check_value("awburst", 32'd0, 32'(axi_awburst)); // FIXED
            check_value("awcache", 32'h3, 32'(axi_awcache)); // modifiable, bufferable
            check_value("awid", 32'(AXI_ID), 32'(axi_awid));
        end
        if (!reset && axi_wvalid)
            check_bit("wlast", 1'b1, axi_wlast); // the only beat is the last
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(2));
        reset        = 1'b1;
        wr_valid     = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        wr_strb      = '0;
        inject_valid = 1'b0;
        inject_count = '0;
        for (int i = 0; i < MEM_BYTES; i++)
            ref_mem[i] = 8'(i) ^ 8'h5a; // same background as the slave memory
        load_trace();
        cycle_limit = CYCLES_PER_LINE * (kind_q.size() + 1);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("reset_wr_ready", 1'b1, wr_ready);
        check_bit("reset_drained", 1'b1, drained);
        check_bit("reset_awvalid", 1'b0, axi_awvalid);
        check_bit("reset_wvalid", 1'b0, axi_wvalid);
        check_bit("reset_bready", 1'b0, axi_bready);
        foreach (kind_q[n])
            run_record(n);
        @(posedge clk);
        wr_valid     <= 1'b0;
        inject_valid <= 1'b0;
        wait_drained();
        compare_memory();
        print_counts();
        if (total_errors() == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- dv/write_trace.txt
# W <byte addr> <data> <strobe>   E <n> : the next n write responses are SLVERR
# C <name> <byte addr of word> <expected word> : memory word once the path has drained
W 00000000 11223344 f
W 00000008 55667788 f
C full_word_00 00000000 11223344
C full_word_08 00000008 55667788
W 00000020 000000a1 1
W 00000020 0000b200 2
W 00000023 00c30000 4
W 00000020 d4000000 8
W 00000020 0000ee00 2
C merged_bytes 00000020 d4c3eea1
W 00000024 cafef00d f
W 00000034 12345678 3
W 00000034 9abc0000 c
C upper_lane_24 00000024 cafef00d
C upper_lane_34 00000034 9abc5678
E 2
W 00000040 deadbeef f
W 00000048 0badf00d f
C error_replay_40 00000040 deadbeef
C error_replay_48 00000048 0badf00d
E 1
W 00000080 00000001 f
W 00000084 00000002 f
W 0000008c 00000004 f
W 00000094 00000005 f
W 00000080 000000ff 1
W 0000009c 00000006 f
C burst_80 00000080 000000ff
C burst_9c 0000009c 00000006

//--- cache_write_path.f
common/cache_pkg.sv
common/axi_pkg.sv
hdl/front_write_port.sv
write_buffer/write_buffer.sv
axi_write/write_channel_axi.sv
hdl/cache_write_path.sv
dv/axi_slave_model.sv
dv/cache_write_path_asserts.sv
dv/cache_write_path_tb.sv

//--- Bender.yml
package:
  name: cache_write_path

sources:
  - common/cache_pkg.sv
  - common/axi_pkg.sv
  - hdl/front_write_port.sv
  - write_buffer/write_buffer.sv
  - axi_write/write_channel_axi.sv
  - hdl/cache_write_path.sv
  - target: test
    files:
      - dv/axi_slave_model.sv
      - dv/cache_write_path_asserts.sv
      - dv/cache_write_path_tb.sv
